// File: design/speech_pkg.sv
`default_nettype none

package speech_pkg;

  // ====================================================================
  // Widths and limits
  // ====================================================================
  localparam int SAMPLE_W       = 8;
  localparam int WORD_W         = 32;
  localparam int FLASH_ADDR_W   = 23;
  localparam int BYTES_PER_WORD = 4;   // Samples packed in one flash word

  // Sample rate divisor, 50 MHz / 3472 is about 14.4 kHz
  localparam int DIV_W = 16;
  localparam logic [DIV_W-1:0] DEFAULT_DIVISOR = 16'd3472;
  localparam logic [DIV_W-1:0] SPEED_STEP      = 16'd100;
  localparam logic [DIV_W-1:0] MIN_DIVISOR     = 16'd200;
  localparam logic [DIV_W-1:0] MAX_DIVISOR     = 16'd6944;

  // ====================================================================
  // Phoneme tables
  // ====================================================================
  localparam int PHONEME_COUNT = 16;
  localparam int CODE_W        = 4;
  localparam logic [CODE_W-1:0] SILENT_CODE = 4'd0;
  localparam int MAX_WORDS = 8;                       // Longest phoneme
  localparam int WORDS_W   = $clog2(MAX_WORDS + 1);

  // First flash word of each code, phonemes stored back to back
  localparam logic [FLASH_ADDR_W-1:0] PHONEME_BASE [PHONEME_COUNT] = '{
    23'd16, 23'd20, 23'd25, 23'd28, 23'd34, 23'd42, 23'd44, 23'd51,
    23'd55, 23'd60, 23'd66, 23'd69, 23'd77, 23'd79, 23'd83, 23'd90
  };

  // Length in words, code 0 is the silent phoneme
  localparam logic [WORDS_W-1:0] PHONEME_WORDS [PHONEME_COUNT] = '{
    4'd4, 4'd5, 4'd3, 4'd6, 4'd8, 4'd2, 4'd7, 4'd4,
    4'd5, 4'd6, 4'd3, 4'd8, 4'd2, 4'd4, 4'd7, 4'd5
  };

  // Level meter
  localparam int LEVEL_WINDOW = 32;
  localparam int LED_COUNT    = 8;
  localparam int LEVEL_STEP   = 16;

  // ====================================================================
  // Types
  // ====================================================================
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_cmd_t;

  typedef struct packed {
    logic                    read;
    logic [FLASH_ADDR_W-1:0] address;
  } flash_cmd_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [WORD_W-1:0] readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [CODE_W-1:0] code;
  } phoneme_req_t;

  typedef struct packed {
    logic    valid;
    sample_t sample;
  } audio_out_t;

endpackage

`default_nettype wire

// File: design/sample_rate_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module sample_rate_ctrl (
  input  wire                           CLK_50M,
  input  wire                           rst_n,
  input  wire speech_pkg::speed_cmd_t   speed,
  output logic [speech_pkg::DIV_W-1:0]  divisor,
  output logic                          sample_tick
);

  logic [speech_pkg::DIV_W-1:0] period;  // Divisor latched at the last wrap
  logic [speech_pkg::DIV_W-1:0] count;

  // Speed commands, reset wins over up, up over down
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      divisor <= speech_pkg::DEFAULT_DIVISOR;
    else if (speed.reset)
      divisor <= speech_pkg::DEFAULT_DIVISOR;
    else if (speed.up)
    begin
      if (divisor < speech_pkg::MIN_DIVISOR + speech_pkg::SPEED_STEP)
        divisor <= speech_pkg::MIN_DIVISOR;       // Fastest rate
      else
        divisor <= divisor - speech_pkg::SPEED_STEP;
    end
    else if (speed.down)
    begin
      if (divisor > speech_pkg::MAX_DIVISOR - speech_pkg::SPEED_STEP)
        divisor <= speech_pkg::MAX_DIVISOR;       // Slowest rate
      else
        divisor <= divisor + speech_pkg::SPEED_STEP;
    end
  end

  // Tick on the last count of each period
  assign sample_tick = (count == period - 1'b1);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count  <= '0;
      period <= speech_pkg::DEFAULT_DIVISOR;
    end
    else if (sample_tick)
    begin
      count  <= '0;
      period <= divisor;  // New rate starts here
    end
    else
      count <= count + 1'b1;
  end

  a_divisor_range: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    (divisor >= speech_pkg::MIN_DIVISOR) && (divisor <= speech_pkg::MAX_DIVISOR)
  ) else $error("divisor %0d outside clamp range", divisor);

endmodule

`default_nettype wire

// File: design/flash_reader.sv
`timescale 1ns/1ns
`default_nettype none

module flash_reader (
  input  wire                                  CLK_50M,
  input  wire                                  rst_n,
  input  wire                                  fetch_start,
  input  wire  [speech_pkg::FLASH_ADDR_W-1:0]  fetch_addr,
  output speech_pkg::flash_cmd_t               flash_cmd,
  input  wire speech_pkg::flash_rsp_t          flash_rsp,
  output logic                                 word_valid,
  output logic [speech_pkg::WORD_W-1:0]        word
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

  state_t                            state;
  logic [speech_pkg::FLASH_ADDR_W-1:0] addr_q;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        S_IDLE: if (fetch_start) state <= S_REQ;
        S_REQ:  if (!flash_rsp.waitrequest) state <= S_WAIT;  // Read accepted
        S_WAIT:
        begin
          if (flash_rsp.readdatavalid)
          begin
            state      <= S_IDLE;
            word_valid <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (state == S_IDLE && fetch_start)
      addr_q <= fetch_addr;
    if (state == S_WAIT && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

  always_comb
  begin
    flash_cmd.read    = (state == S_REQ);
    flash_cmd.address = addr_q;
  end

  a_addr_hold: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    flash_cmd.read && flash_rsp.waitrequest |=> flash_cmd.read && $stable(flash_cmd.address)
  ) else $error("flash read dropped or address moved during waitrequest");

  // Sequencer must wait for the previous word
  a_one_outstanding: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    fetch_start |-> state == S_IDLE
  ) else $error("fetch_start while a flash read is outstanding");

endmodule

`default_nettype wire

// File: design/sample_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module sample_sequencer (
  input  wire                                  CLK_50M,
  input  wire                                  rst_n,
  input  wire speech_pkg::phoneme_req_t        req,
  output logic                                 req_ready,
  input  wire                                  sample_tick,
  output logic                                 fetch_start,
  output logic [speech_pkg::FLASH_ADDR_W-1:0]  fetch_addr,
  input  wire                                  word_valid,
  input  wire  [speech_pkg::WORD_W-1:0]        word,
  output speech_pkg::audio_out_t               audio
);

  localparam int SMP_W  = $clog2(speech_pkg::MAX_WORDS * speech_pkg::BYTES_PER_WORD + 1);
  localparam int BYTE_W = $clog2(speech_pkg::BYTES_PER_WORD);

  logic                              busy;
  logic                              started;    // First sample is out
  logic                              silent_q;
  logic                              fetch_pending;
  logic                              play_full;
  logic                              pre_full;
  logic [BYTE_W-1:0]                 byte_cnt;
  logic [SMP_W-1:0]                  samples_left;
  logic [speech_pkg::WORDS_W-1:0]    words_left;  // Words not yet requested
  logic [speech_pkg::WORD_W-1:0]     play_buf;
  logic [speech_pkg::WORD_W-1:0]     pre_buf;
  logic                              audio_valid_q;
  speech_pkg::sample_t               sample_q;
  logic                              accept;
  logic                              consume;
  logic                              drain;
  logic                              finish;

  // ====================================================================
  // Handshakes and per-tick events
  // ====================================================================
  assign req_ready   = !busy;
  assign accept      = req.valid && req_ready;
  assign fetch_start = busy && (words_left != '0) && !fetch_pending && !pre_full;
  assign consume     = sample_tick && busy && (samples_left != '0) && (silent_q || play_full);
  assign drain       = consume && !silent_q &&
                       (byte_cnt == BYTE_W'(speech_pkg::BYTES_PER_WORD - 1));
  assign finish      = audio_valid_q && busy && (samples_left == '0);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      busy          <= 1'b0;
      started       <= 1'b0;
      silent_q      <= 1'b0;
      fetch_pending <= 1'b0;
      play_full     <= 1'b0;
      pre_full      <= 1'b0;
      byte_cnt      <= '0;
      samples_left  <= '0;
      words_left    <= '0;
      audio_valid_q <= 1'b0;
    end
    else
    begin
      audio_valid_q <= consume;
      if (accept)
      begin
        busy         <= 1'b1;
        started      <= 1'b0;
        silent_q     <= (req.code == speech_pkg::SILENT_CODE);
        samples_left <= SMP_W'(speech_pkg::PHONEME_WORDS[req.code]) *
                        SMP_W'(speech_pkg::BYTES_PER_WORD);
        words_left   <= (req.code == speech_pkg::SILENT_CODE) ?
                        '0 : speech_pkg::PHONEME_WORDS[req.code];  // Silence reads nothing
        byte_cnt     <= '0;
        play_full    <= 1'b0;
        pre_full     <= 1'b0;
      end
      else
      begin
        if (finish)
          busy <= 1'b0;
        if (consume)
        begin
          started      <= 1'b1;
          samples_left <= samples_left - 1'b1;
          byte_cnt     <= byte_cnt + 1'b1;
        end
        if (word_valid)
          fetch_pending <= 1'b0;
        if (fetch_start)
        begin
          fetch_pending <= 1'b1;
          words_left    <= words_left - 1'b1;
        end

        // Word slots, a returning word never meets a full prefetch slot
        if (drain)
        begin
          play_full <= pre_full || word_valid;
          pre_full  <= 1'b0;
        end
        else if (word_valid)
        begin
          if (play_full)
            pre_full <= 1'b1;
          else
            play_full <= 1'b1;
        end
      end
    end
  end

  // ====================================================================
  // Address walk, word buffers and sample output
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (accept)
      fetch_addr <= speech_pkg::PHONEME_BASE[req.code];
    else if (fetch_start)
      fetch_addr <= fetch_addr + 1'b1;

    if (drain)
      play_buf <= pre_full ? pre_buf : word;
    else
    begin
      if (consume)
        play_buf <= play_buf >> speech_pkg::SAMPLE_W;  // Low byte plays first
      if (word_valid && !play_full)
        play_buf <= word;
    end

    if (word_valid && play_full && !drain)
      pre_buf <= word;

    if (consume)
      sample_q <= silent_q ? '0 : play_buf[speech_pkg::SAMPLE_W-1:0];
  end

  always_comb
  begin
    audio.valid  = audio_valid_q;
    audio.sample = sample_q;
  end

  // Prefetch has to keep ahead of the sample rate
  a_no_underrun: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    sample_tick && busy && started && (samples_left != '0) && !silent_q |-> play_full
  ) else $error("sample tick found no word ready");

endmodule

`default_nettype wire

// File: design/level_meter.sv
`timescale 1ns/1ns
`default_nettype none

module level_meter (
  input  wire                                CLK_50M,
  input  wire                                rst_n,
  input  wire speech_pkg::audio_out_t        audio,
  output logic [speech_pkg::LED_COUNT-1:0]   leds
);

  localparam int SHIFT = $clog2(speech_pkg::LEVEL_WINDOW);
  localparam int SUM_W = speech_pkg::SAMPLE_W + SHIFT;  // 32 x 128 fits

  logic [SHIFT-1:0]                  count;
  logic [SUM_W-1:0]                  sum;
  logic [SUM_W-1:0]                  sum_next;
  logic [speech_pkg::SAMPLE_W-1:0]   mag;
  logic [speech_pkg::SAMPLE_W-1:0]   avg;
  logic [speech_pkg::LED_COUNT-1:0]  bar;

  always_comb
  begin
    // Magnitude of -128 comes out as 8'h80
    mag      = audio.sample[speech_pkg::SAMPLE_W-1] ? ~audio.sample + 1'b1 : audio.sample;
    sum_next = sum + SUM_W'(mag);
    avg      = sum_next[SUM_W-1:SHIFT];  // Divide by window length
    for (int i = 0; i < speech_pkg::LED_COUNT; i++)
      bar[i] = avg > speech_pkg::SAMPLE_W'(i * speech_pkg::LEVEL_STEP);
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count <= '0;
      sum   <= '0;
      leds  <= '0;
    end
    else if (audio.valid)
    begin
      count <= count + 1'b1;  // Wraps at window end
      if (count == SHIFT'(speech_pkg::LEVEL_WINDOW - 1))
      begin
        sum  <= '0;
        leds <= bar;
      end
      else
        sum <= sum_next;
    end
  end

endmodule

`default_nettype wire

// File: design/speech_player.sv
`timescale 1ns/1ns
`default_nettype none

module speech_player (
  input  wire                                CLK_50M,
  input  wire                                rst_n,
  input  wire speech_pkg::phoneme_req_t      req,
  output logic                               req_ready,
  input  wire speech_pkg::speed_cmd_t        speed,
  output speech_pkg::flash_cmd_t             flash_cmd,
  input  wire speech_pkg::flash_rsp_t        flash_rsp,
  output speech_pkg::audio_out_t             audio,
  output logic [speech_pkg::LED_COUNT-1:0]   leds,
  output logic [speech_pkg::DIV_W-1:0]       divisor
);

  logic                                sample_tick;
  logic                                fetch_start;
  logic [speech_pkg::FLASH_ADDR_W-1:0] fetch_addr;
  logic                                word_valid;
  logic [speech_pkg::WORD_W-1:0]       word;

  // ====================================================================
  // Sample rate, flash fetch, playback and level display
  // ====================================================================
  sample_rate_ctrl u_rate (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed       (speed),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  flash_reader u_flash (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .flash_cmd   (flash_cmd),
    .flash_rsp   (flash_rsp),
    .word_valid  (word_valid),
    .word        (word)
  );

  sample_sequencer u_seq (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .req         (req),
    .req_ready   (req_ready),
    .sample_tick (sample_tick),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .word_valid  (word_valid),
    .word        (word),
    .audio       (audio)
  );

  level_meter u_meter (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .audio   (audio),   // Same stream as the top output
    .leds    (leds)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic CLK_50M,
  output logic rst_n
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (5) @(posedge CLK_50M);
    rst_n <= 1'b1;  // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: verification/speech_player_tb.sv
`timescale 1ns/1ns
`default_nettype none

module speech_player_tb;

  localparam int NUM_PLAYBACK   = 40;
  localparam int TIMEOUT_CYCLES = (NUM_PLAYBACK + 1) * speech_pkg::MAX_WORDS *
                                  speech_pkg::BYTES_PER_WORD *
                                  int'(speech_pkg::MAX_DIVISOR) + 2000;

  logic                                CLK_50M;
  logic                                rst_n;
  speech_pkg::phoneme_req_t            req = '0;
  logic                                req_ready;
  speech_pkg::speed_cmd_t              speed = '0;
  speech_pkg::flash_cmd_t              flash_cmd;
  speech_pkg::flash_rsp_t              flash_rsp = '0;
  speech_pkg::audio_out_t              audio;
  logic [speech_pkg::LED_COUNT-1:0]    leds;
  logic [speech_pkg::DIV_W-1:0]        divisor;

  // Reference model state
  logic [speech_pkg::WORD_W-1:0]       flash_mem [0:127];
  speech_pkg::sample_t                 exp_q [$];
  bit                                  first_q [$];   // First sample of a phoneme
  logic [speech_pkg::FLASH_ADDR_W-1:0] addr_q [$];
  logic [speech_pkg::DIV_W-1:0]        exp_div;
  logic [speech_pkg::LED_COUNT-1:0]    exp_leds;
  bit                                  leds_due;
  int                                  level_sum;
  int                                  level_count;
  int                                  silent_left;
  int                                  cycle;
  int                                  last_sample_cycle;
  string                               test_name;
  speech_pkg::speed_cmd_t              mix_cmd;

  // Flash model state
  bit                                  outstanding;
  int                                  stall_left;
  int                                  latency;
  logic [speech_pkg::FLASH_ADDR_W-1:0] rd_addr;

  tb_clock_gen clock_gen (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n)
  );

  speech_player dut (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .req       (req),
    .req_ready (req_ready),
    .speed     (speed),
    .flash_cmd (flash_cmd),
    .flash_rsp (flash_rsp),
    .audio     (audio),
    .leds      (leds),
    .divisor   (divisor)
  );

  // ====================================================================
  // Compare tasks and model helpers
  // ====================================================================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_sample(input string test, input speech_pkg::sample_t expected,
                              input speech_pkg::sample_t actual);
    if (actual !== expected)
      stop_on_error($sformatf("error: %s expected %0d actual %0d", test, expected, actual));
  endtask

  task automatic check_divisor(input string test, input logic [speech_pkg::DIV_W-1:0] expected,
                               input logic [speech_pkg::DIV_W-1:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("error: %s expected %0d actual %0d", test, expected, actual));
  endtask

  task automatic check_leds(input string test, input logic [speech_pkg::LED_COUNT-1:0] expected,
                            input logic [speech_pkg::LED_COUNT-1:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("error: %s expected %b actual %b", test, expected, actual));
  endtask

  task automatic check_bit(input string test, input logic expected, input logic actual);
    if (actual !== expected)
      stop_on_error($sformatf("error: %s expected %b actual %b", test, expected, actual));
  endtask

  // Divisor arithmetic with reset before up before down
  function automatic logic [speech_pkg::DIV_W-1:0] next_divisor(
    input logic [speech_pkg::DIV_W-1:0] current, input speech_pkg::speed_cmd_t cmd);
    int d;
    d = int'(current);
    if (cmd.reset)
      d = int'(speech_pkg::DEFAULT_DIVISOR);
    else if (cmd.up)
      d = (d - int'(speech_pkg::SPEED_STEP) < int'(speech_pkg::MIN_DIVISOR)) ?
          int'(speech_pkg::MIN_DIVISOR) : d - int'(speech_pkg::SPEED_STEP);
    else if (cmd.down)
      d = (d + int'(speech_pkg::SPEED_STEP) > int'(speech_pkg::MAX_DIVISOR)) ?
          int'(speech_pkg::MAX_DIVISOR) : d + int'(speech_pkg::SPEED_STEP);
    return speech_pkg::DIV_W'(d);
  endfunction

  // Expected bytes and read addresses of one accepted phoneme
  task automatic load_phoneme(input logic [speech_pkg::CODE_W-1:0] code);
    logic [speech_pkg::WORD_W-1:0] w;
    int n;
    n = int'(speech_pkg::PHONEME_WORDS[code]);
    if (code == speech_pkg::SILENT_CODE)
      silent_left = n * speech_pkg::BYTES_PER_WORD;
    for (int i = 0; i < n; i++)
    begin
      w = '0;
      if (code != speech_pkg::SILENT_CODE)
      begin
        w = flash_mem[speech_pkg::PHONEME_BASE[code] + i];
        addr_q.push_back(speech_pkg::FLASH_ADDR_W'(speech_pkg::PHONEME_BASE[code] + i));
      end
      for (int b = 0; b < speech_pkg::BYTES_PER_WORD; b++)
      begin
        exp_q.push_back(w[speech_pkg::SAMPLE_W*b +: speech_pkg::SAMPLE_W]);  // Low byte first
        first_q.push_back(i == 0 && b == 0);
      end
    end
  endtask

  task automatic take_sample(input speech_pkg::sample_t actual);
    speech_pkg::sample_t expected;
    bit first;
    if (exp_q.size() == 0)
      stop_on_error("an audio sample appeared while no phoneme was playing");
    else
    begin
      expected = exp_q.pop_front();
      first    = first_q.pop_front();
      check_sample(test_name, expected, actual);
      if (!first)
        check_divisor("sample_spacing", exp_div,
                      speech_pkg::DIV_W'(cycle - last_sample_cycle));
      last_sample_cycle = cycle;
      if (silent_left != 0)
        silent_left--;
      level_sum += (expected < 0) ? -int'(expected) : int'(expected);
      level_count++;
      if (level_count == speech_pkg::LEVEL_WINDOW)
      begin
        for (int i = 0; i < speech_pkg::LED_COUNT; i++)
          exp_leds[i] = (level_sum / speech_pkg::LEVEL_WINDOW) > i * speech_pkg::LEVEL_STEP;
        leds_due    = 1'b1;
        level_sum   = 0;
        level_count = 0;
      end
    end
  endtask

  // ====================================================================
  // Monitor, flash model and timeout
  // ====================================================================
  always @(posedge CLK_50M)
  begin
    if (rst_n)
    begin
      cycle++;
      if (cycle > TIMEOUT_CYCLES)
        stop_on_error($sformatf("timeout: the run went past %0d cycles", TIMEOUT_CYCLES));
      if (leds_due)
      begin
        check_leds("level_meter", exp_leds, leds);
        leds_due = 1'b0;
      end
      if (req.valid && req_ready)
        load_phoneme(req.code);
      if (flash_cmd.read && !flash_rsp.waitrequest)
      begin
        if (addr_q.size() == 0)
          stop_on_error("flash read accepted with no word left to fetch");
        else if (addr_q[0] !== flash_cmd.address)
          stop_on_error($sformatf("error: flash_stall expected address %0d actual %0d",
                                  addr_q[0], flash_cmd.address));
        else
          void'(addr_q.pop_front());
      end
      if (flash_cmd.read && silent_left != 0)
        stop_on_error("flash read issued while the silent phoneme plays");
      if (audio.valid)
        take_sample(audio.sample);
    end
  end

  always @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      outstanding = 1'b0;
      stall_left  = $urandom_range(0, 3);
      flash_rsp   <= '0;
    end
    else
    begin
      flash_rsp.readdatavalid <= 1'b0;
      if (flash_cmd.read && outstanding)
        stop_on_error("flash read issued while another read is outstanding");
      if (flash_cmd.read && !flash_rsp.waitrequest)
      begin
        outstanding = 1'b1;
        rd_addr     = flash_cmd.address;
        latency     = $urandom_range(1, 5);
        stall_left  = $urandom_range(0, 3);  // Stall for the next read
      end
      else if (flash_cmd.read && stall_left > 0)
        stall_left--;
      if (outstanding)
      begin
        latency--;
        if (latency == 0)
        begin
          flash_rsp.readdatavalid <= 1'b1;
          flash_rsp.readdata      <= flash_mem[rd_addr];
          outstanding = 1'b0;
        end
      end
      flash_rsp.waitrequest <= (stall_left != 0);
    end
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  task automatic pulse_speed(input speech_pkg::speed_cmd_t cmd, input string test);
    speed <= cmd;
    @(posedge CLK_50M);
    speed   <= '0;
    exp_div = next_divisor(exp_div, cmd);
    @(posedge CLK_50M);
    check_divisor(test, exp_div, divisor);
  endtask

  task automatic send_phoneme(input logic [speech_pkg::CODE_W-1:0] code);
    req.valid <= 1'b1;
    req.code  <= code;
    do
      @(posedge CLK_50M);
    while (!req_ready);
    req.valid <= 1'b0;
  endtask

  task automatic wait_playback_done();
    do
      @(posedge CLK_50M);
    while (exp_q.size() != 0 || !req_ready);
  endtask

  initial
  begin
    void'($urandom(32'h7151_3e23));
    for (int a = 0; a < 128; a++)
      flash_mem[a] = $urandom;
    exp_div   = speech_pkg::DEFAULT_DIVISOR;
    test_name = "reset";
    wait (rst_n);
    @(posedge CLK_50M);
    check_bit("reset req_ready", 1'b1, req_ready);
    check_bit("reset audio valid", 1'b0, audio.valid);
    check_bit("reset flash read", 1'b0, flash_cmd.read);
    check_leds("reset leds", '0, leds);
    check_divisor("reset divisor", speech_pkg::DEFAULT_DIVISOR, divisor);

    // Fastest rate keeps the run short
    repeat (33)
      pulse_speed('{up: 1'b1, down: 1'b0, reset: 1'b0}, "speed_up");

    test_name = "playback";
    for (int n = 0; n < NUM_PLAYBACK; n++)
    begin
      send_phoneme(speech_pkg::CODE_W'($urandom_range(1, 15)));
      repeat ($urandom_range(0, 20)) @(posedge CLK_50M);
    end
    wait_playback_done();

    test_name = "silent";
    send_phoneme(speech_pkg::SILENT_CODE);
    wait_playback_done();

    // Slow clamp, fast clamp, then a mix with simultaneous pulses
    repeat (80)
    begin
      pulse_speed('{up: 1'b0, down: 1'b1, reset: 1'b0}, "speed_down");
      repeat ($urandom_range(0, 3)) @(posedge CLK_50M);
    end
    repeat (80)
    begin
      pulse_speed('{up: 1'b1, down: 1'b0, reset: 1'b0}, "speed_up");
      repeat ($urandom_range(0, 3)) @(posedge CLK_50M);
    end
    repeat (120)
    begin
      mix_cmd = 3'($urandom_range(1, 7));
      pulse_speed(mix_cmd, "speed_mix");
      repeat ($urandom_range(0, 3)) @(posedge CLK_50M);
    end

    if (addr_q.size() != 0)
      stop_on_error("some phoneme words were never read from flash");
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: speech_player.f
design/speech_pkg.sv
design/sample_rate_ctrl.sv
design/flash_reader.sv
design/sample_sequencer.sv
design/level_meter.sv
design/speech_player.sv
verification/tb_clock_gen.sv
verification/speech_player_tb.sv
